//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module bottomTb

sim:
	verilator --binary --timing -f filelist.f --top-module bottomTb -Mdir obj_dir -o bottomSim
	@out="$$(./obj_dir/bottomSim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

//--- filelist.f
hdl/bottomPkg.sv
hdl/regFile.sv
hdl/aluOperands.sv
hdl/pointerRegs.sv
hdl/incDec.sv
hdl/bottomTop.sv
verif/bottomChecker.sv
verif/bottomTb.sv

//--- hdl/aluOperands.sv
`timescale 1ns/10ps

module aluOperands (
	input  logic                        CLK,
	input  logic                        rstN,
	input  logic [bottomPkg::dataW-1:0] opAVal,
	input  logic [bottomPkg::dataW-1:0] opBVal,
	input  logic [bottomPkg::dataW-1:0] regA,
	input  logic                        maskAll,    // Force all of operand 2 high
	input  logic                        nibbleMask, // Force selected high-nibble bits
	input  logic [3:0]                  maskBits,
	output logic [bottomPkg::dataW-1:0] alu,        // Operand 1
	output logic [bottomPkg::dataW-1:0] dv,         // Operand 2
	output logic                        bq4,
	output logic                        bq5,
	output logic                        bq7
);

	import bottomPkg::*;

	logic [dataW-1:0] opAQ;
	logic [dataW-1:0] opBQ;
	logic [dataW-1:0] maskVec;
	logic [3:0]       hiMask;

	// Operands captured every cycle
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			opAQ <= opRst;
			opBQ <= opRst;
		end else begin
			opAQ <= opAVal;
			opBQ <= opBVal;
		end
	end

	assign hiMask = nibbleMask ? maskBits : 4'b0000; // Bit 4+i per maskBits[i]

	always_comb begin
		if (maskAll) begin
			maskVec = '1;
		end else begin
			maskVec = {hiMask, 4'b0000};
		end
	end

	assign alu = ~opAQ;
	assign dv  = ~opBQ | maskVec; // Masked bits read as 1

	// Accumulator tests, straight from A
	assign bq4 = |regA[3:1];
	assign bq5 = |regA[7:5];
	assign bq7 = regA[4] | regA[7];

endmodule

//--- hdl/bottomPkg.sv
package bottomPkg;

	// Bus widths
	localparam int dataW = 8;
	localparam int addrW = 16;

	// Register file size, B through W
	localparam int numRegs = 9;

	// Reset values
	localparam logic [dataW-1:0] regRst  = 8'h00;
	localparam logic [dataW-1:0] opRst   = 8'h00;
	localparam logic [addrW-1:0] pcRst   = 16'h0000;
	localparam logic [addrW-1:0] spRst   = 16'hFFFE;
	localparam logic [addrW-1:0] addrRst = 16'h0000;

	// Interrupt vectors live in page zero
	localparam logic [dataW-1:0] irqPage = 8'h00;

	// Register codes, also the index into the register array
	typedef enum logic [3:0] {
		selB = 4'd0,
		selC = 4'd1,
		selD = 4'd2,
		selE = 4'd3,
		selH = 4'd4,
		selL = 4'd5,
		selA = 4'd6,
		selZ = 4'd7,
		selW = 4'd8
	} regSelT;

	typedef enum logic {
		srcData = 1'b0, // External data bus
		srcRes  = 1'b1  // ALU result
	} wrSrcT;

	typedef enum logic [1:0] {
		pairPc = 2'd0,
		pairSp = 2'd1,
		pairHl = 2'd2,
		pairZw = 2'd3
	} pairSelT;

	typedef enum logic [1:0] {
		iduPass = 2'd0,
		iduInc  = 2'd1,
		iduDec  = 2'd2
	} iduOpT;

	typedef enum logic [1:0] {
		pcHold = 2'd0,
		pcIdu  = 2'd1,
		pcZw   = 2'd2,
		pcVec  = 2'd3
	} pcSrcT;

	typedef enum logic [1:0] {
		spHold = 2'd0,
		spIdu  = 2'd1,
		spZw   = 2'd2
	} spSrcT;

endpackage

//--- hdl/bottomTop.sv
`timescale 1ns/10ps

module bottomTop (
	input  logic                        CLK,
	input  logic                        rstN,
	input  logic [bottomPkg::dataW-1:0] dataIn,
	input  logic [bottomPkg::dataW-1:0] res,     // ALU result
	input  logic                        wrEn,
	input  bottomPkg::regSelT           wrSel,
	input  bottomPkg::wrSrcT            wrSrc,
	input  bottomPkg::regSelT           opASel,
	input  bottomPkg::regSelT           opBSel,
	input  logic                        maskAll,
	input  logic                        nibbleMask,
	input  logic [3:0]                  maskBits,
	input  bottomPkg::pairSelT          pairSel,
	input  bottomPkg::iduOpT            iduOp,
	input  logic                        pairwise,
	input  logic                        addrHold,
	input  bottomPkg::pcSrcT            pcSrc,
	input  bottomPkg::spSrcT            spSrc,
	input  logic [7:3]                  irqVec,
	output logic [bottomPkg::dataW-1:0] alu,
	output logic [bottomPkg::dataW-1:0] dv,
	output logic                        bq4,
	output logic                        bq5,
	output logic                        bq7,
	output logic                        tempC,   // Flags parked in Z
	output logic                        tempH,
	output logic                        tempN,
	output logic                        tempZ,
	output logic [bottomPkg::addrW-1:0] addr,
	output logic [bottomPkg::addrW-1:0] pcOut
);

	import bottomPkg::*;

	logic [dataW-1:0] opAVal;
	logic [dataW-1:0] opBVal;
	logic [dataW-1:0] regA;
	logic [addrW-1:0] hl;
	logic [addrW-1:0] zw;
	logic [addrW-1:0] pc;
	logic [addrW-1:0] sp;
	logic [addrW-1:0] iduIn;
	logic [addrW-1:0] iduOut;

	regFile uRegFile (
		.CLK(CLK), .rstN(rstN), .dataIn(dataIn), .res(res),
		.wrEn(wrEn), .wrSel(wrSel), .wrSrc(wrSrc),
		.opASel(opASel), .opBSel(opBSel),
		.opAVal(opAVal), .opBVal(opBVal), .regA(regA), .hl(hl), .zw(zw)
	);

	aluOperands uAluOperands (
		.CLK(CLK), .rstN(rstN), .opAVal(opAVal), .opBVal(opBVal), .regA(regA),
		.maskAll(maskAll), .nibbleMask(nibbleMask), .maskBits(maskBits),
		.alu(alu), .dv(dv), .bq4(bq4), .bq5(bq5), .bq7(bq7)
	);

	// Pair that feeds the IDU and the address register
	always_comb begin
		case (pairSel)
			pairPc:  iduIn = pc;
			pairSp:  iduIn = sp;
			pairHl:  iduIn = hl;
			pairZw:  iduIn = zw;
			default: iduIn = pc;
		endcase
	end

	incDec uIncDec (
		.CLK(CLK), .rstN(rstN), .iduIn(iduIn), .iduOp(iduOp),
		.pairwise(pairwise), .addrHold(addrHold), .iduOut(iduOut), .addr(addr)
	);

	pointerRegs uPointerRegs (
		.CLK(CLK), .rstN(rstN), .iduOut(iduOut), .zw(zw),
		.pcSrc(pcSrc), .spSrc(spSrc), .irqVec(irqVec), .pc(pc), .sp(sp)
	);

	assign pcOut = pc;

	assign tempC = zw[4];
	assign tempH = zw[5];
	assign tempN = zw[6];
	assign tempZ = zw[7];

endmodule

//--- hdl/incDec.sv
`timescale 1ns/10ps

module incDec (
	input  logic                        CLK,
	input  logic                        rstN,
	input  logic [bottomPkg::addrW-1:0] iduIn,
	input  bottomPkg::iduOpT            iduOp,
	input  logic                        pairwise, // Bytes wrap on their own
	input  logic                        addrHold, // Freeze the address bus
	output logic [bottomPkg::addrW-1:0] iduOut,
	output logic [bottomPkg::addrW-1:0] addr      // External address bus
);

	import bottomPkg::*;

	logic [addrW-1:0] stepFull;
	logic [dataW-1:0] stepHi;
	logic [dataW-1:0] stepLo;
	logic             isDec;

	assign isDec = (iduOp == iduDec);

	// Full 16-bit carry chain
	assign stepFull = isDec ? iduIn - 16'd1 : iduIn + 16'd1;

	// Split halves, no carry between bytes
	assign stepHi = isDec ? iduIn[15:8] - 8'd1 : iduIn[15:8] + 8'd1;
	assign stepLo = isDec ? iduIn[7:0] - 8'd1 : iduIn[7:0] + 8'd1;

	always_comb begin
		case (iduOp)
			iduInc, iduDec: iduOut = pairwise ? {stepHi, stepLo} : stepFull;
			iduPass:        iduOut = iduIn;
			default:        iduOut = iduIn;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			addr <= addrRst;
		end else if (!addrHold) begin
			addr <= iduIn;
		end
	end

endmodule

//--- hdl/pointerRegs.sv
`timescale 1ns/10ps

module pointerRegs (
	input  logic                        CLK,
	input  logic                        rstN,
	input  logic [bottomPkg::addrW-1:0] iduOut,
	input  logic [bottomPkg::addrW-1:0] zw,
	input  bottomPkg::pcSrcT            pcSrc,
	input  bottomPkg::spSrcT            spSrc,
	input  logic [7:3]                  irqVec,  // Vector bits from the interrupt logic
	output logic [bottomPkg::addrW-1:0] pc,
	output logic [bottomPkg::addrW-1:0] sp
);

	import bottomPkg::*;

	logic [addrW-1:0] vecAddr;
	logic [addrW-1:0] pcNext;
	logic [addrW-1:0] spNext;

	// Restart and interrupt entry points sit on 8-byte boundaries
	assign vecAddr = {irqPage, irqVec, 3'b000};

	always_comb begin
		case (pcSrc)
			pcIdu:   pcNext = iduOut;
			pcZw:    pcNext = zw;       // Jumps and returns
			pcVec:   pcNext = vecAddr;
			pcHold:  pcNext = pc;
			default: pcNext = pc;
		endcase
	end

	always_comb begin
		case (spSrc)
			spIdu:   spNext = iduOut;   // Push and pop steps
			spZw:    spNext = zw;       // LD SP from immediate
			spHold:  spNext = sp;
			default: spNext = sp;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			pc <= pcRst;
		end else begin
			pc <= pcNext;
		end
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			sp <= spRst;
		end else begin
			sp <= spNext;
		end
	end

endmodule

//--- hdl/regFile.sv
`timescale 1ns/10ps

module regFile (
	input  logic                          CLK,
	input  logic                          rstN,
	input  logic [bottomPkg::dataW-1:0]   dataIn,  // External data bus
	input  logic [bottomPkg::dataW-1:0]   res,     // ALU result
	input  logic                          wrEn,
	input  bottomPkg::regSelT             wrSel,
	input  bottomPkg::wrSrcT              wrSrc,
	input  bottomPkg::regSelT             opASel,
	input  bottomPkg::regSelT             opBSel,
	output logic [bottomPkg::dataW-1:0]   opAVal,
	output logic [bottomPkg::dataW-1:0]   opBVal,
	output logic [bottomPkg::dataW-1:0]   regA,    // Accumulator for the test bits
	output logic [bottomPkg::addrW-1:0]   hl,
	output logic [bottomPkg::addrW-1:0]   zw       // Temporary pair, Z is the low byte
);

	import bottomPkg::*;

	logic [dataW-1:0] regs [numRegs]; // B C D E H L A Z W
	logic [dataW-1:0] wrData;
	logic             wrLegal;

	// Unused codes read as zero
	function automatic logic [dataW-1:0] readReg(input regSelT sel);
		logic [dataW-1:0] rd;
		rd = regRst;
		if (int'(sel) < numRegs) begin
			rd = regs[int'(sel)];
		end
		return rd;
	endfunction

	always_comb begin
		case (wrSrc)
			srcRes:  wrData = res;
			srcData: wrData = dataIn;
			default: wrData = dataIn;
		endcase
	end

	assign wrLegal = int'(wrSel) < numRegs;

	// Single write port, new value visible after the edge
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= regRst;
			end
		end else if (wrEn && wrLegal) begin
			regs[int'(wrSel)] <= wrData;
		end
	end

	// Two combinational read ports
	always_comb begin
		opAVal = readReg(opASel);
		opBVal = readReg(opBSel);
	end

	// Direct taps for the accumulator and the address pairs
	assign regA = regs[int'(selA)];
	assign hl   = {regs[int'(selH)], regs[int'(selL)]};
	assign zw   = {regs[int'(selW)], regs[int'(selZ)]};

	// BC and DE only reach the outside through the read ports
	// so the codes below are the ones the sequencer uses for them
	// selB, selC, selD, selE map onto array slots 0 to 3

endmodule

//--- verif/bottomChecker.sv
`timescale 1ns/10ps

module bottomChecker (
	input  logic                        CLK,
	input  logic                        rstN,
	input  logic [bottomPkg::dataW-1:0] dataIn,
	input  logic [bottomPkg::dataW-1:0] res,
	input  logic                        wrEn,
	input  bottomPkg::regSelT           wrSel,
	input  bottomPkg::wrSrcT            wrSrc,
	input  bottomPkg::regSelT           opASel,
	input  bottomPkg::regSelT           opBSel,
	input  logic                        maskAll,
	input  logic                        nibbleMask,
	input  logic [3:0]                  maskBits,
	input  bottomPkg::pairSelT          pairSel,
	input  bottomPkg::iduOpT            iduOp,
	input  logic                        pairwise,
	input  logic                        addrHold,
	input  bottomPkg::pcSrcT            pcSrc,
	input  bottomPkg::spSrcT            spSrc,
	input  logic [7:3]                  irqVec,
	input  logic [bottomPkg::dataW-1:0] alu,
	input  logic [bottomPkg::dataW-1:0] dv,
	input  logic                        bq4,
	input  logic                        bq5,
	input  logic                        bq7,
	input  logic                        tempC,
	input  logic                        tempH,
	input  logic                        tempN,
	input  logic                        tempZ,
	input  logic [bottomPkg::addrW-1:0] addr,
	input  logic [bottomPkg::addrW-1:0] pcOut,
	output int                          errCount,
	output int                          checkCount
);

	import bottomPkg::*;

	logic [7:0]  mRegs [9]; // B C D E H L A Z W
	logic [7:0]  mOpA;
	logic [7:0]  mOpB;
	logic [15:0] mPc;
	logic [15:0] mSp;
	logic [15:0] mAddr;
	logic [15:0] mIduIn;
	logic [15:0] mIduOut;
	logic [7:0]  mMask;
	logic [7:0]  expAlu;
	logic [7:0]  expDv;
	int          errs = 0;
	int          checks = 0;

	assign errCount   = errs;
	assign checkCount = checks;

	// Reference IDU step
	function automatic logic [15:0] stepPair(input logic [15:0] v, input iduOpT op,
			input logic split);
		logic [7:0]  hi;
		logic [7:0]  lo;
		logic [15:0] r;
		hi = v[15:8];
		lo = v[7:0];
		r  = v;
		if (op == iduInc) begin
			r = split ? {hi + 8'd1, lo + 8'd1} : v + 16'd1;
		end else if (op == iduDec) begin
			r = split ? {hi - 8'd1, lo - 8'd1} : v - 16'd1;
		end
		return r;
	endfunction

	task automatic checkVal(input string name, input logic [15:0] expVal,
			input logic [15:0] actVal);
		checks++;
		if (actVal !== expVal) begin
			errs++;
			$display("ERR %s expected %h actual %h at %0t", name, expVal, actVal, $time);
		end
	endtask

	always_comb begin
		case (pairSel)
			pairSp:  mIduIn = mSp;
			pairHl:  mIduIn = {mRegs[4], mRegs[5]};
			pairZw:  mIduIn = {mRegs[8], mRegs[7]};
			default: mIduIn = mPc;
		endcase
		mIduOut = stepPair(mIduIn, iduOp, pairwise);
	end

	always_comb begin
		mMask = 8'h00;
		for (int i = 0; i < 4; i++) begin
			if (nibbleMask && maskBits[i]) begin
				mMask[4 + i] = 1'b1;
			end
		end
		if (maskAll) begin
			mMask = 8'hFF;
		end
	end

	assign expAlu = ~mOpA;
	assign expDv  = ~mOpB | mMask;

	always @(posedge CLK) begin
		if (!rstN) begin
			for (int i = 0; i < 9; i++) begin
				mRegs[i] <= 8'h00;
			end
			mOpA  <= 8'h00;
			mOpB  <= 8'h00;
			mPc   <= 16'h0000;
			mSp   <= 16'hFFFE;
			mAddr <= 16'h0000;
		end else begin
			if (wrEn) begin
				mRegs[int'(wrSel)] <= (wrSrc == srcRes) ? res : dataIn;
			end
			mOpA <= mRegs[int'(opASel)]; // Old value on a same-edge write
			mOpB <= mRegs[int'(opBSel)];
			if (!addrHold) begin
				mAddr <= mIduIn;
			end
			case (pcSrc)
				pcIdu:   mPc <= mIduOut;
				pcZw:    mPc <= {mRegs[8], mRegs[7]};
				pcVec:   mPc <= {8'h00, irqVec, 3'b000};
				default: mPc <= mPc;
			endcase
			case (spSrc)
				spIdu:   mSp <= mIduOut;
				spZw:    mSp <= {mRegs[8], mRegs[7]};
				default: mSp <= mSp;
			endcase
		end
	end

	// Mid-cycle compare, inputs and outputs both settled
	always @(negedge CLK) begin
		checkVal("alu", 16'(expAlu), 16'(alu));
		checkVal("dv", 16'(expDv), 16'(dv));
		checkVal("bq4", 16'(mRegs[6][1] | mRegs[6][2] | mRegs[6][3]), 16'(bq4));
		checkVal("bq5", 16'(mRegs[6][5] | mRegs[6][6] | mRegs[6][7]), 16'(bq5));
		checkVal("bq7", 16'(mRegs[6][4] | mRegs[6][7]), 16'(bq7));
		checkVal("tempC", 16'(mRegs[7][4]), 16'(tempC));
		checkVal("tempH", 16'(mRegs[7][5]), 16'(tempH));
		checkVal("tempN", 16'(mRegs[7][6]), 16'(tempN));
		checkVal("tempZ", 16'(mRegs[7][7]), 16'(tempZ));
		checkVal("addr", mAddr, addr);
		checkVal("pcOut", mPc, pcOut);
	end

endmodule

//--- verif/bottomTb.sv
`timescale 1ns/10ps

module bottomTb;

	import bottomPkg::*;

	localparam int numCycles   = 2000;
	localparam int resetCycles = 5;
	localparam int edgeLimit   = 200; // Poll steps of 1 ns

	logic        CLK;
	logic        rstN;
	logic [7:0]  dataIn;
	logic [7:0]  res;
	logic        wrEn;
	regSelT      wrSel;
	wrSrcT       wrSrc;
	regSelT      opASel;
	regSelT      opBSel;
	logic        maskAll;
	logic        nibbleMask;
	logic [3:0]  maskBits;
	pairSelT     pairSel;
	iduOpT       iduOp;
	logic        pairwise;
	logic        addrHold;
	pcSrcT       pcSrc;
	spSrcT       spSrc;
	logic [7:3]  irqVec;
	logic [7:0]  alu;
	logic [7:0]  dv;
	logic        bq4;
	logic        bq5;
	logic        bq7;
	logic        tempC;
	logic        tempH;
	logic        tempN;
	logic        tempZ;
	logic [15:0] addr;
	logic [15:0] pcOut;
	int          errCount;
	int          checkCount;

	bottomTop uut (
		.CLK(CLK), .rstN(rstN), .dataIn(dataIn), .res(res),
		.wrEn(wrEn), .wrSel(wrSel), .wrSrc(wrSrc), .opASel(opASel), .opBSel(opBSel),
		.maskAll(maskAll), .nibbleMask(nibbleMask), .maskBits(maskBits),
		.pairSel(pairSel), .iduOp(iduOp), .pairwise(pairwise), .addrHold(addrHold),
		.pcSrc(pcSrc), .spSrc(spSrc), .irqVec(irqVec),
		.alu(alu), .dv(dv), .bq4(bq4), .bq5(bq5), .bq7(bq7),
		.tempC(tempC), .tempH(tempH), .tempN(tempN), .tempZ(tempZ),
		.addr(addr), .pcOut(pcOut)
	);

	bottomChecker chk (.*);

	initial CLK = 1'b0;
	always #50 CLK = ~CLK; // 100 ns period

	// Polls half a nanosecond off the clock grid, so no same-step race
	task automatic waitRise();
		int steps;
		steps = 0;
		#0.5;
		while (CLK !== 1'b0 && steps < edgeLimit) begin
			#1;
			steps++;
		end
		while (CLK !== 1'b1 && steps < edgeLimit) begin
			#1;
			steps++;
		end
		if (steps >= edgeLimit) begin
			$display("Timeout, no rising edge on CLK within %0d ns", edgeLimit);
			$display("CHECKS FAILED");
			$finish;
		end
	endtask

	task automatic nextCycle();
		waitRise();
		#4.5; // Inputs change 5 ns after the edge
	endtask

	task automatic driveIdle();
		dataIn     = 8'h00;
		res        = 8'h00;
		wrEn       = 1'b0;
		wrSel      = selB;
		wrSrc      = srcData;
		opASel     = selA;
		opBSel     = selB;
		maskAll    = 1'b0;
		nibbleMask = 1'b0;
		maskBits   = 4'h0;
		pairSel    = pairPc;
		iduOp      = iduPass;
		pairwise   = 1'b0;
		addrHold   = 1'b0;
		pcSrc      = pcHold;
		spSrc      = spHold;
		irqVec     = 5'h00;
	endtask

	task automatic driveRandom();
		int unsigned pick;
		dataIn     = ($urandom_range(3, 0) == 0) ? 8'hFF : 8'($urandom); // Carry edge cases
		res        = ($urandom_range(3, 0) == 0) ? 8'h00 : 8'($urandom);
		wrEn       = 1'($urandom);
		wrSel      = regSelT'(4'($urandom_range(8, 0)));
		wrSrc      = wrSrcT'(1'($urandom));
		opASel     = regSelT'(4'($urandom_range(8, 0)));
		opBSel     = regSelT'(4'($urandom_range(8, 0)));
		maskAll    = ($urandom_range(3, 0) == 0);
		nibbleMask = ($urandom_range(2, 0) == 0);
		maskBits   = 4'($urandom);
		pairSel    = pairSelT'(2'($urandom_range(3, 0)));
		iduOp      = iduOpT'(2'($urandom_range(2, 0)));
		pairwise   = ($urandom_range(3, 0) == 0);
		addrHold   = ($urandom_range(3, 0) == 0);
		pick       = $urandom_range(5, 0);
		pcSrc      = (pick > 3) ? pcHold : pcSrcT'(pick[1:0]); // Lean toward HOLD
		spSrc      = spSrcT'(2'($urandom_range(2, 0)));
		irqVec     = 5'($urandom);
	endtask

	task automatic applyReset();
		rstN = 1'b0;
		driveIdle();
		for (int i = 0; i < resetCycles; i++) begin
			nextCycle();
		end
		rstN = 1'b1;
		pairSel = pairSp; // SP reset value onto addr
		// Read back every register before any write
		for (int i = 0; i < numRegs; i += 2) begin
			opASel = regSelT'(4'(i));
			opBSel = regSelT'(4'((i + 1) % numRegs));
			nextCycle();
		end
	endtask

	initial begin
		void'($urandom(32'hec096b9c));
		rstN = 1'b0;
		driveIdle();
		applyReset();
		for (int i = 0; i < numCycles; i++) begin
			if (i == numCycles / 2) begin
				applyReset(); // Second reset mid-run
			end
			driveRandom();
			nextCycle();
		end
		driveIdle();
		nextCycle();
		nextCycle();
		$display("Run complete, %0d checks, %0d errors", checkCount, errCount);
		if (errCount == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule
